/* source/recovery_params.svh */
`ifndef RECOVERY_PARAMS_SVH
`define RECOVERY_PARAMS_SVH

// Width of the program counter and of the branch target in bits.
`define RECOVERY_DATA_WIDTH 32

// Number of Hsiao parity bits per data word.
// The SEC-DED code needs log2 of the data width plus two check bits.
`define RECOVERY_PARITY_WIDTH 7

// Depth of the commit buffer in records.
// The core holds exactly this many credits after reset.
`define RECOVERY_INGRESS_DEPTH 4

`endif

/* source/recovery_pkg.sv */
`include "recovery_params.svh"

package recovery_pkg;

  // One commit record as it leaves the core.
  // The branch target only matters when the branch flag is set.
  typedef struct packed {
    logic [`RECOVERY_DATA_WIDTH-1:0] pc;
    logic                            branch;
    logic [`RECOVERY_DATA_WIDTH-1:0] branch_addr;
  } commit_rec_t;

  // A protected word with the parity bits in the upper part.
  typedef logic [`RECOVERY_PARITY_WIDTH+`RECOVERY_DATA_WIDTH-1:0] codeword_t;

  // The syndrome has one bit per parity bit.
  typedef logic [`RECOVERY_PARITY_WIDTH-1:0] syndrome_t;

  // Parity-check columns for the data bits, one column per bit.
  typedef syndrome_t hmatrix_t [`RECOVERY_DATA_WIDTH];

  // Builds the Hsiao check matrix from the weight-three columns in ascending order.
  // All columns are distinct and of odd weight, which keeps double errors detectable.
  function automatic hmatrix_t hsiao_matrix();
    hmatrix_t    cols;
    int unsigned idx;
    cols = '{default: '0};
    idx  = 0;
    for (int unsigned v = 1; v < 2 ** `RECOVERY_PARITY_WIDTH; v++) begin
      if (($countones(v[`RECOVERY_PARITY_WIDTH-1:0]) == 3) && (idx < `RECOVERY_DATA_WIDTH)) begin
        cols[idx] = v[`RECOVERY_PARITY_WIDTH-1:0];
        idx++;
      end
    end
    return cols;
  endfunction

endpackage : recovery_pkg

/* source/checkpoint_if.sv */
`timescale 1ns/1ps
`include "recovery_params.svh"

// Carries one commit record from the ingress buffer to the protected storage.
// A record is taken at each rising edge where valid is high.
interface checkpoint_if;

  // High in each cycle that carries a record.
  logic                            valid;
  // Program counter of the committed instruction.
  logic [`RECOVERY_DATA_WIDTH-1:0] pc;
  // Set when the committed instruction was a taken branch.
  logic                            branch;
  // Target of that branch.
  logic [`RECOVERY_DATA_WIDTH-1:0] branch_addr;

  // The buffer side drives the record.
  modport source (
    output valid,
    output pc,
    output branch,
    output branch_addr
  );

  // The storage side samples the record.
  modport sink (
    input valid,
    input pc,
    input branch,
    input branch_addr
  );

endinterface : checkpoint_if

/* source/checkpoint_ingress.sv */
`timescale 1ns/1ps
`include "recovery_params.svh"

module checkpoint_ingress (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      commit_valid_i,
  input  recovery_pkg::commit_rec_t commit_i,
  input  logic                      recover_i,
  output logic                      credit_o,
  checkpoint_if.source              ckpt
);
  import recovery_pkg::*;

  localparam int unsigned depth     = `RECOVERY_INGRESS_DEPTH;
  localparam int unsigned ptr_width = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_width = $clog2(depth + 1);

  commit_rec_t          mem_q [depth];
  commit_rec_t          head;
  logic [ptr_width-1:0] wr_ptr_q;
  logic [ptr_width-1:0] rd_ptr_q;
  logic [cnt_width-1:0] count_q;
  logic                 push;
  logic                 pop;

  // Pointers wrap at the buffer depth, which need not be a power of two.
  function automatic logic [ptr_width-1:0] next_ptr(logic [ptr_width-1:0] ptr);
    return (ptr == ptr_width'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // The core only sends while it holds a credit, so every commit is a push.
  assign push = commit_valid_i;
  // Recovery freezes the storage, so records stay here while it is active.
  assign pop  = (count_q != '0) && !recover_i;
  assign head = mem_q[rd_ptr_q];

  // Each pop frees one entry and hands a credit back to the core.
  assign credit_o         = pop;
  assign ckpt.valid       = pop;
  assign ckpt.pc          = head.pc;
  assign ckpt.branch      = head.branch;
  assign ckpt.branch_addr = head.branch_addr;

  always_ff @(posedge clk_i) begin : mem_write
    if (push)
      mem_q[wr_ptr_q] <= commit_i;
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin : ptr_update
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      count_q <= count_q + cnt_width'(push) - cnt_width'(pop);
    end
  end

  // A push into a full buffer means the core sent without a credit.
  no_push_when_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_i |-> (count_q != cnt_width'(depth)))
    else $error("commit pushed into a full ingress buffer");

  // Credits may only come back for entries that the pointers show as filled.
  credit_needs_data : assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_o |-> ((wr_ptr_q != rd_ptr_q) || (count_q == cnt_width'(depth))))
    else $error("credit returned from an empty ingress buffer");

endmodule : checkpoint_ingress

/* source/hsiao_ecc_enc.sv */
`timescale 1ns/1ps
`include "recovery_params.svh"

module hsiao_ecc_enc (
  input  logic [`RECOVERY_DATA_WIDTH-1:0] data_i,
  output recovery_pkg::codeword_t         code_o
);
  import recovery_pkg::*;

  // Check matrix columns, shared with the decoder through the package.
  localparam hmatrix_t h_col = hsiao_matrix();

  syndrome_t parity;

  // Each parity bit is the XOR of the data bits whose column has a one in that row.
  // Accumulating whole columns gives the same result row by row.
  always_comb begin
    parity = '0;
    for (int i = 0; i < `RECOVERY_DATA_WIDTH; i++) begin
      parity = parity ^ ({`RECOVERY_PARITY_WIDTH{data_i[i]}} & h_col[i]);
    end
  end

  // Parity goes on top and the data stays readable in the lower bits.
  // The code is linear, so an all-zero word encodes to an all-zero codeword.
  assign code_o = {parity, data_i};

endmodule : hsiao_ecc_enc

/* source/hsiao_ecc_dec.sv */
`timescale 1ns/1ps
`include "recovery_params.svh"

module hsiao_ecc_dec (
  input  recovery_pkg::codeword_t         code_i,
  output logic [`RECOVERY_DATA_WIDTH-1:0] data_o,
  output recovery_pkg::syndrome_t         syndrome_o,
  output logic                            single_err_o,
  output logic                            double_err_o
);
  import recovery_pkg::*;

  localparam hmatrix_t h_col = hsiao_matrix();

  syndrome_t                       syndrome;
  logic [`RECOVERY_DATA_WIDTH-1:0] data_raw;
  logic [`RECOVERY_DATA_WIDTH-1:0] flip;

  assign data_raw = code_i[`RECOVERY_DATA_WIDTH-1:0];

  // The syndrome is the stored parity XOR the parity recomputed from the data.
  // It is zero for a clean word.
  always_comb begin
    syndrome = code_i[`RECOVERY_DATA_WIDTH +: `RECOVERY_PARITY_WIDTH];
    for (int i = 0; i < `RECOVERY_DATA_WIDTH; i++) begin
      syndrome = syndrome ^ ({`RECOVERY_PARITY_WIDTH{data_raw[i]}} & h_col[i]);
    end
  end

  // A single data-bit error leaves exactly that bit's column as syndrome.
  // Columns are unique, so at most one bit is flipped back.
  always_comb begin
    for (int i = 0; i < `RECOVERY_DATA_WIDTH; i++) begin
      flip[i] = (syndrome == h_col[i]);
    end
  end

  assign data_o     = data_raw ^ flip;
  assign syndrome_o = syndrome;

  // All columns have odd weight, so any single error gives an odd syndrome.
  // Errors in the parity bits give weight one and need no data correction.
  assign single_err_o = ^syndrome;
  // Two errors cancel to an even, nonzero syndrome that cannot be located.
  assign double_err_o = (syndrome != '0) && !(^syndrome);

endmodule : hsiao_ecc_dec

/* source/recovery_pc.sv */
`timescale 1ns/1ps
`include "recovery_params.svh"

module recovery_pc (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic                            recover_i,
  input  logic                            fault_inject_i,
  input  logic [5:0]                      fault_bit_i,
  checkpoint_if.sink                      ckpt,
  output logic [`RECOVERY_DATA_WIDTH-1:0] recovery_pc_o,
  output logic                            recovery_branch_o,
  output logic [`RECOVERY_DATA_WIDTH-1:0] recovery_branch_addr_o,
  output logic                            recovery_corrected_o,
  output logic                            recovery_uncorrectable_o
);
  import recovery_pkg::*;

  localparam int unsigned code_width = $bits(codeword_t);

  codeword_t                       pc_d;
  codeword_t                       pc_q;
  codeword_t                       branch_addr_d;
  codeword_t                       branch_addr_q;
  codeword_t                       fault_mask;
  logic                            branch_q;
  logic [`RECOVERY_DATA_WIDTH-1:0] pc_out;
  logic [`RECOVERY_DATA_WIDTH-1:0] branch_addr_out;
  logic                            pc_single;
  logic                            pc_double;
  logic                            addr_single;
  logic                            addr_double;

  // Both fields are encoded before they reach the registers.
  hsiao_ecc_enc i_pc_enc (
    .data_i ( ckpt.pc ),
    .code_o ( pc_d    )
  );

  hsiao_ecc_enc i_branch_addr_enc (
    .data_i ( ckpt.branch_addr ),
    .code_o ( branch_addr_d    )
  );

  // One bit of the stored PC codeword, parity bits included, can be upset on purpose.
  assign fault_mask = codeword_t'(1) << fault_bit_i;

  // A zero PC is never a valid restart point, so it does not overwrite the last one.
  // Fault injection only acts in cycles without a record or a clear.
  always_ff @(posedge clk_i, negedge rst_ni) begin : pc_sampler
    if (!rst_ni) begin
      pc_q <= '0;
    end else if (clear_i) begin
      pc_q <= '0;
    end else if (ckpt.valid) begin
      if (ckpt.pc != '0)
        pc_q <= pc_d;
    end else if (fault_inject_i) begin
      pc_q <= pc_q ^ fault_mask;
    end
  end

  // The target is kept only from records that took a branch.
  always_ff @(posedge clk_i, negedge rst_ni) begin : branch_addr_sampler
    if (!rst_ni)
      branch_addr_q <= '0;
    else if (clear_i)
      branch_addr_q <= '0;
    else if (ckpt.valid && ckpt.branch)
      branch_addr_q <= branch_addr_d;
  end

  // The flag follows every record.
  always_ff @(posedge clk_i, negedge rst_ni) begin : branch_sampler
    if (!rst_ni)
      branch_q <= 1'b0;
    else if (clear_i)
      branch_q <= 1'b0;
    else if (ckpt.valid)
      branch_q <= ckpt.branch;
  end

  hsiao_ecc_dec i_pc_dec (
    .code_i       ( pc_q      ),
    .data_o       ( pc_out    ),
    .syndrome_o   (           ),
    .single_err_o ( pc_single ),
    .double_err_o ( pc_double )
  );

  hsiao_ecc_dec i_branch_addr_dec (
    .code_i       ( branch_addr_q   ),
    .data_o       ( branch_addr_out ),
    .syndrome_o   (                 ),
    .single_err_o ( addr_single     ),
    .double_err_o ( addr_double     )
  );

  // Outputs stay zero outside recovery.
  // The stored target only counts when the stored flag says a branch was taken.
  assign recovery_pc_o            = recover_i ? pc_out : '0;
  assign recovery_branch_o        = recover_i && branch_q;
  assign recovery_branch_addr_o   = (recover_i && branch_q) ? branch_addr_out : '0;
  assign recovery_corrected_o     = recover_i && (pc_single || (branch_q && addr_single));
  assign recovery_uncorrectable_o = recover_i && (pc_double || (branch_q && addr_double));

  // Injection must land inside the codeword.
  fault_bit_in_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    fault_inject_i |-> (fault_bit_i < code_width))
    else $error("fault bit outside the PC codeword");

  // A stored PC decodes back to the value that was written, through encoder and decoder.
  pc_round_trip : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ckpt.valid && !clear_i && (ckpt.pc != '0)) |=> (pc_out == $past(ckpt.pc)))
    else $error("stored PC does not decode to the written value");

endmodule : recovery_pc

/* source/recovery_unit.sv */
`timescale 1ns/1ps
`include "recovery_params.svh"

module recovery_unit (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Zeroes the stored state at the next edge.
  input  logic                            clear_i,
  // Holds commits in the buffer and opens the read-out.
  input  logic                            recover_i,
  // Commit stream from the core, one record per credit.
  input  logic                            commit_valid_i,
  input  logic [`RECOVERY_DATA_WIDTH-1:0] commit_pc_i,
  input  logic                            commit_branch_i,
  input  logic [`RECOVERY_DATA_WIDTH-1:0] commit_branch_addr_i,
  // Upsets one bit of the stored PC codeword.
  input  logic                            fault_inject_i,
  input  logic [5:0]                      fault_bit_i,
  // One pulse per record that leaves the buffer.
  output logic                            credit_o,
  // Corrected restart state.
  output logic [`RECOVERY_DATA_WIDTH-1:0] recovery_pc_o,
  output logic                            recovery_branch_o,
  output logic [`RECOVERY_DATA_WIDTH-1:0] recovery_branch_addr_o,
  output logic                            recovery_corrected_o,
  output logic                            recovery_uncorrectable_o
);
  import recovery_pkg::*;

  commit_rec_t commit_rec;

  // Record between the buffer and the protected storage.
  checkpoint_if ckpt_bus ();

  // The flat core ports are gathered into one record for the buffer.
  assign commit_rec.pc          = commit_pc_i;
  assign commit_rec.branch      = commit_branch_i;
  assign commit_rec.branch_addr = commit_branch_addr_i;

  checkpoint_ingress i_ingress (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .commit_valid_i ( commit_valid_i ),
    .commit_i       ( commit_rec     ),
    .recover_i      ( recover_i      ),
    .credit_o       ( credit_o       ),
    .ckpt           ( ckpt_bus       )
  );

  // Storage, decoders and output gating live in one block.
  recovery_pc i_recovery_pc (
    .clk_i                    ( clk_i                    ),
    .rst_ni                   ( rst_ni                   ),
    .clear_i                  ( clear_i                  ),
    .recover_i                ( recover_i                ),
    .fault_inject_i           ( fault_inject_i           ),
    .fault_bit_i              ( fault_bit_i              ),
    .ckpt                     ( ckpt_bus                 ),
    .recovery_pc_o            ( recovery_pc_o            ),
    .recovery_branch_o        ( recovery_branch_o        ),
    .recovery_branch_addr_o   ( recovery_branch_addr_o   ),
    .recovery_corrected_o     ( recovery_corrected_o     ),
    .recovery_uncorrectable_o ( recovery_uncorrectable_o )
  );

endmodule : recovery_unit

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

// Free-running clock and a reset that stays low for the first few cycles.
module tb_clock_gen #(
  parameter real         period       = 4.0,
  parameter int unsigned reset_cycles = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(period / 2.0) clk_o = ~clk_o;
  end

  // Release lands just after an edge so that no flop sees it change at the edge.
  initial begin
    rst_no = 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule : tb_clock_gen

/* test/tb_recovery_unit.sv */
`timescale 1ns/1ps
`include "recovery_params.svh"

module tb_recovery_unit;
  import recovery_pkg::*;

  localparam int unsigned depth        = `RECOVERY_INGRESS_DEPTH;
  localparam int unsigned code_bits    = `RECOVERY_DATA_WIDTH + `RECOVERY_PARITY_WIDTH;
  localparam int unsigned n_bursts     = 60;
  localparam int unsigned n_faults     = 30;
  localparam int unsigned burst_max    = 8;
  // A burst, a full drain and the read-out check bound the cycles of each round.
  localparam int unsigned burst_cycles = burst_max + depth + 4;
  localparam int unsigned stim_cycles  = (n_bursts + n_faults + 8) * burst_cycles + 4 * n_faults;
  localparam int unsigned timeout_cycles = 4 * stim_cycles;

  logic                            clk;
  logic                            rst_n;
  logic                            clear;
  logic                            recover;
  logic                            commit_valid;
  logic [`RECOVERY_DATA_WIDTH-1:0] commit_pc;
  logic                            commit_branch;
  logic [`RECOVERY_DATA_WIDTH-1:0] commit_addr;
  logic                            fault_inject;
  logic [5:0]                      fault_bit;
  logic                            credit;
  logic [`RECOVERY_DATA_WIDTH-1:0] rec_pc;
  logic                            rec_branch;
  logic [`RECOVERY_DATA_WIDTH-1:0] rec_addr;
  logic                            rec_corrected;
  logic                            rec_uncorrectable;

  integer      seed = 32'h8262;
  int unsigned credits;
  int unsigned accepted;
  int unsigned credit_pulses;
  int unsigned checks;
  int unsigned errors;
  int unsigned cycle_count;
  // Records that the core has sent and that have not left the buffer yet.
  commit_rec_t pending [$];
  // Reference copy of the protected state.
  logic [`RECOVERY_DATA_WIDTH-1:0] exp_pc;
  logic                            exp_branch;
  logic [`RECOVERY_DATA_WIDTH-1:0] exp_addr;

  tb_clock_gen i_clock_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  recovery_unit dut (
    .clk_i                    ( clk               ),
    .rst_ni                   ( rst_n             ),
    .clear_i                  ( clear             ),
    .recover_i                ( recover           ),
    .commit_valid_i           ( commit_valid      ),
    .commit_pc_i              ( commit_pc         ),
    .commit_branch_i          ( commit_branch     ),
    .commit_branch_addr_i     ( commit_addr       ),
    .fault_inject_i           ( fault_inject      ),
    .fault_bit_i              ( fault_bit         ),
    .credit_o                 ( credit            ),
    .recovery_pc_o            ( rec_pc            ),
    .recovery_branch_o        ( rec_branch        ),
    .recovery_branch_addr_o   ( rec_addr          ),
    .recovery_corrected_o     ( rec_corrected     ),
    .recovery_uncorrectable_o ( rec_uncorrectable )
  );

  // Every credit pulse means one record leaves the buffer.
  // It reaches the registers at the next edge, so the model applies the store rules now.
  always @(negedge clk) begin : credit_monitor
    commit_rec_t rec;
    if (rst_n && credit) begin
      credit_pulses++;
      credits++;
      assert (pending.size() != 0) else begin
        errors++;
        $display("t=%0t credit returned while no commit was pending", $time);
      end
      if (pending.size() != 0) begin
        rec = pending.pop_front();
        if (rec.pc != '0)
          exp_pc = rec.pc;
        exp_branch = rec.branch;
        if (rec.branch)
          exp_addr = rec.branch_addr;
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout after %0d cycles, the run did not finish", cycle_count);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Outputs read zero outside recovery, and the target reads zero without a stored branch.
  // The read-out is sampled mid-cycle and the task returns at the next drive point.
  task automatic check_outputs(input logic exp_corrected);
    logic gate_addr;
    @(negedge clk);
    gate_addr = recover && exp_branch;
    check_value("recovery_pc_o", rec_pc, recover ? exp_pc : '0);
    check_value("recovery_branch_o", rec_branch, gate_addr);
    check_value("recovery_branch_addr_o", rec_addr, gate_addr ? exp_addr : '0);
    check_value("recovery_corrected_o", rec_corrected, recover && exp_corrected);
    check_value("recovery_uncorrectable_o", rec_uncorrectable, 1'b0);
    next_cycle();
  endtask

  // About a quarter of the records carry a zero PC to hit the nonzero-PC rule.
  function automatic commit_rec_t random_record();
    commit_rec_t rec;
    rec.pc          = (($random(seed) & 3) == 0) ? '0 : 32'($random(seed));
    rec.branch      = 1'($random(seed));
    rec.branch_addr = 32'($random(seed));
    return rec;
  endfunction

  task automatic drive_commit(input commit_rec_t rec);
    commit_valid  = 1'b1;
    commit_pc     = rec.pc;
    commit_branch = rec.branch;
    commit_addr   = rec.branch_addr;
    pending.push_back(rec);
    credits--;
    accepted++;
  endtask

  task automatic run_burst(input int unsigned cycles, input logic allow_recover);
    for (int unsigned c = 0; c < cycles; c++) begin
      recover = allow_recover && (($random(seed) & 3) == 0);
      commit_valid = 1'b0;
      if ((credits > 0) && (($random(seed) & 1) != 0))
        drive_commit(random_record());
      next_cycle();
    end
    commit_valid = 1'b0;
  endtask

  // Wait until every credit is back, which means the last record is already stored.
  task automatic drain_and_check();
    recover      = 1'b0;
    commit_valid = 1'b0;
    while (credits != depth)
      next_cycle();
    recover = 1'b1;
    check_outputs(1'b0);
  endtask

  task automatic report_test(input int unsigned num, input string name);
    $display("test %0d %s finished with %0d errors so far", num, name, errors);
  endtask

  initial begin : stimulus
    commit_rec_t rec;
    int unsigned start_pulses;
    int unsigned bit_pos;
    clear         = 1'b0;
    recover       = 1'b0;
    commit_valid  = 1'b0;
    commit_pc     = '0;
    commit_branch = 1'b0;
    commit_addr   = '0;
    fault_inject  = 1'b0;
    fault_bit     = '0;
    credits       = depth;
    accepted      = 0;
    credit_pulses = 0;
    checks        = 0;
    errors        = 0;
    cycle_count   = 0;
    exp_pc        = '0;
    exp_branch    = 1'b0;
    exp_addr      = '0;
    @(posedge rst_n);
    next_cycle();

    for (int unsigned b = 0; b < n_bursts; b++) begin
      run_burst(1 + ($unsigned($random(seed)) % burst_max), 1'b1);
      drain_and_check();
    end
    report_test(1, "random commit bursts");

    // Outside recovery everything reads zero, and a non-branch record hides the target.
    recover = 1'b0;
    check_outputs(1'b0);
    rec        = random_record();
    rec.pc     = 32'h0000_1000;
    rec.branch = 1'b0;
    drive_commit(rec);
    next_cycle();
    drain_and_check();
    report_test(2, "output gating");

    // Records sent during recovery must stay in the buffer.
    start_pulses = credit_pulses;
    for (int unsigned i = 0; i < depth; i++) begin
      drive_commit(random_record());
      next_cycle();
      commit_valid = 1'b0;
      check_outputs(1'b0);
    end
    next_cycle();
    check_value("credit_o pulses during recovery", credit_pulses, start_pulses);
    drain_and_check();
    report_test(3, "recovery back-pressure");

    clear = 1'b1;
    next_cycle();
    clear      = 1'b0;
    exp_pc     = '0;
    exp_branch = 1'b0;
    exp_addr   = '0;
    check_outputs(1'b0);
    for (int unsigned b = 0; b < 4; b++) begin
      run_burst(burst_max, 1'b0);
      drain_and_check();
    end
    report_test(4, "clear");

    // A second injection at the same bit restores the stored codeword.
    for (int unsigned f = 0; f < n_faults; f++) begin
      run_burst(1 + ($unsigned($random(seed)) % burst_max), 1'b0);
      drain_and_check();
      bit_pos      = $unsigned($random(seed)) % code_bits;
      fault_bit    = 6'(bit_pos);
      fault_inject = 1'b1;
      next_cycle();
      fault_inject = 1'b0;
      check_outputs(1'b1);
      fault_inject = 1'b1;
      next_cycle();
      fault_inject = 1'b0;
      check_outputs(1'b0);
    end
    report_test(5, "single-bit fault injection");

    // An empty buffer outside recovery must stay silent on the credit line.
    recover = 1'b0;
    repeat (depth + 1) next_cycle();
    check_value("credit_o pulses", credit_pulses, accepted);
    check_value("pending commits", pending.size(), 0);
    report_test(6, "credit accounting");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule : tb_recovery_unit

/* recovery_unit.f */
+incdir+source
source/recovery_pkg.sv
source/checkpoint_if.sv
source/checkpoint_ingress.sv
source/hsiao_ecc_enc.sv
source/hsiao_ecc_dec.sv
source/recovery_pc.sv
source/recovery_unit.sv
test/tb_clock_gen.sv
test/tb_recovery_unit.sv

/* Bender.yml */
package:
  name: recovery_unit

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/recovery_pkg.sv
      - source/checkpoint_if.sv
      - source/checkpoint_ingress.sv
      - source/hsiao_ecc_enc.sv
      - source/hsiao_ecc_dec.sv
      - source/recovery_pc.sv
      - source/recovery_unit.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_recovery_unit.sv
